/* sources.f */
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
test/tb_clock.sv
test/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_rv_core --Mdir obj_dir -o tb_rv_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '** FAIL **' sim.log; then
  echo "testbench reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0

/* test/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

  localparam int period       = 20;
  localparam int reset_cycles = 8;
  localparam int cycle_limit  = 40;  // per program
  localparam int hold_cycles  = 5;   // watched after halt
  localparam int row_cycles   = cycle_limit + reset_cycles + hold_cycles + 4;
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  typedef struct packed {
    logic [7:0][31:0] prog;
    logic [31:0]      chk_addr;
    logic [31:0]      want;
  } row_t;

  logic             clk;
  logic             rst_n;
  logic             restart;
  logic             fill_mem;
  logic             halt;
  logic [31:0]      pc;
  logic [31:0]      imem_rdata;
  logic [31:0]      dmem_rdata;
  logic [31:0]      imem_off;
  dmem_req_t        dmem_req;
  logic [31:0]      imem [8];
  logic [31:0]      dmem [256];
  logic [31:0]      mem_init [256];
  row_t             tbl [$];
  string            names [$];
  logic [7:0][31:0] pbuf;
  int               pn;
  int               errors;
  int               passed;
  int               failed;
  bit               tbl_ready;

  tb_clock #(.half_period(period / 2), .reset_cycles(reset_cycles)) i_tb_clock (
    .restart (restart),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  rv_core i_rv_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .imem_rdata (imem_rdata),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  // instruction memory starts at reset_pc, ebreak outside the program
  assign imem_off   = pc - reset_pc;
  assign imem_rdata = (imem_off < 32'd32) ? imem[imem_off[4:2]] : ebreak_word;
  assign dmem_rdata = dmem_req.ren ? dmem[dmem_req.addr[9:2]] : 32'h0;

  always @(posedge clk) begin
    if (fill_mem) begin
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= mem_init[i];
      end
    end else if (dmem_req.wen) begin
      for (int k = 0; k < 4; k++) begin
        if (dmem_req.wmask[k]) begin
          dmem[dmem_req.addr[9:2]][8*k +: 8] <= dmem_req.wdata[8*k +: 8]; // lane k, byte k
        end
      end
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic emit(input logic [31:0] instr);
    pbuf[pn] = instr;
    pn = pn + 1;
  endtask

  // lui + addi, upper part rounded for the sign of the low 12 bits
  task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
    logic [31:0] up;
    up = val + 32'h800;
    emit(u_type(up[31:12], rd, op_lui));
    emit(i_type(val[11:0], rd, 3'b000, rd, op_imm));
  endtask

  task automatic add_row(input string name, input logic [31:0] addr, input logic [31:0] want);
    row_t r;
    for (int i = pn; i < 8; i++) begin
      pbuf[i] = ebreak_word;
    end
    r.prog     = pbuf;
    r.chk_addr = addr;
    r.want     = want;
    tbl.push_back(r);
    names.push_back(name);
    pn = 0;
  endtask

  // x3 = x1 op x2 (or op imm), stored at 0x100
  task automatic op_row(input string name, input bit use_imm, input logic [2:0] f3,
                        input logic [6:0] f7, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] want);
    load_const(5'd1, a);
    if (use_imm) begin
      emit(i_type({f7, b[4:0]}, 5'd1, f3, 5'd3, op_imm));
    end else begin
      load_const(5'd2, b);
      emit(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
    end
    emit(s_type(12'h100, 5'd3, 5'd0, 3'b010));
    emit(ebreak_word);
    add_row(name, 32'h100, want);
  endtask

  task automatic build_alu_rows();
    logic [31:0] a;
    logic [31:0] b;
    a = 32'hffff_ff9c; // -100
    b = 32'h0f0f_5a5a;
    op_row("add", 0, 3'b000, 7'h00, a, b, a + b);
    op_row("sub", 0, 3'b000, 7'h20, a, b, a - b);
    op_row("xor", 0, 3'b100, 7'h00, a, b, a ^ b);
    op_row("or", 0, 3'b110, 7'h00, a, b, a | b);
    op_row("and", 0, 3'b111, 7'h00, a, b, a & b);
    op_row("slt neg", 0, 3'b010, 7'h00, a, b, 32'd1);
    op_row("sltu neg", 0, 3'b011, 7'h00, a, b, 32'd0); // huge as unsigned
    op_row("slt swap", 0, 3'b010, 7'h00, b, a, 32'd0);
    op_row("sltu swap", 0, 3'b011, 7'h00, b, a, 32'd1);
    a = 32'h8765_4321;
    b = 32'h0000_0027; // only the low 5 bits count, shift by 7
    op_row("sll", 0, 3'b001, 7'h00, a, b, a << 7);
    op_row("srl", 0, 3'b101, 7'h00, a, b, a >> 7);
    op_row("sra", 0, 3'b101, 7'h20, a, b, (a >> 7) | ~(32'hffff_ffff >> 7));
    op_row("slli", 1, 3'b001, 7'h00, a, b, a << 7);
    op_row("srli", 1, 3'b101, 7'h00, a, b, a >> 7);
    op_row("srai", 1, 3'b101, 7'h20, a, b, (a >> 7) | ~(32'hffff_ffff >> 7));
  endtask

  task automatic build_flow_rows();
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  bf [6];
    int          pair_a [4];
    int          pair_b [4];
    bf     = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    pair_a = '{5, 5, -1, 1};
    pair_b = '{5, 6, 1, -1};
    for (int j = 0; j < 6; j++) begin
      for (int p = 0; p < 4; p++) begin
        a = pair_a[p];
        b = pair_b[p];
        emit(i_type(a[11:0], 5'd0, 3'b000, 5'd1, op_imm));
        emit(i_type(b[11:0], 5'd0, 3'b000, 5'd2, op_imm));
        emit(b_type(13'd12, 5'd2, 5'd1, bf[j]));
        emit(i_type(12'h011, 5'd0, 3'b000, 5'd5, op_imm)); // fall-through marker
        emit(j_type(21'd8, 5'd0));
        emit(i_type(12'h022, 5'd0, 3'b000, 5'd5, op_imm)); // taken marker
        emit(s_type(12'h104, 5'd5, 5'd0, 3'b010));
        emit(ebreak_word);
        add_row($sformatf("branch f3=%0d a=%0d b=%0d", bf[j], pair_a[p], pair_b[p]),
                32'h104, branch_taken(bf[j], a, b) ? 32'h22 : 32'h11);
      end
    end
    emit(j_type(21'd8, 5'd6));
    emit(ebreak_word);
    emit(s_type(12'h108, 5'd6, 5'd0, 3'b010));
    emit(ebreak_word);
    add_row("jal link", 32'h108, reset_pc + 32'd4);
    emit(u_type(20'h0, 5'd7, op_auipc));
    emit(i_type(12'd13, 5'd7, 3'b000, 5'd6, op_jalr)); // odd target, bit 0 dropped
    emit(ebreak_word);
    emit(s_type(12'h10c, 5'd6, 5'd0, 3'b010));
    emit(ebreak_word);
    add_row("jalr link", 32'h10c, reset_pc + 32'd8);
    emit(u_type(20'habcde, 5'd3, op_lui));
    emit(s_type(12'h110, 5'd3, 5'd0, 3'b010));
    emit(ebreak_word);
    add_row("lui", 32'h110, 32'habcd_e000);
    emit(i_type(12'h0, 5'd0, 3'b000, 5'd0, op_imm));
    emit(i_type(12'h0, 5'd0, 3'b000, 5'd0, op_imm));
    emit(u_type(20'h12345, 5'd3, op_auipc)); // sits at reset_pc + 8
    emit(s_type(12'h114, 5'd3, 5'd0, 3'b010));
    emit(ebreak_word);
    add_row("auipc", 32'h114, reset_pc + 32'd8 + 32'h1234_5000);
  endtask

  task automatic build_mem_rows();
    logic [31:0] w;
    logic [31:0] e;
    logic [31:0] v;
    logic [31:0] addr;
    logic [3:0]  mask;
    logic [2:0]  lf [5];
    int          lsize [5];
    int          idx;
    lf    = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    lsize = '{1, 2, 4, 1, 2};
    idx   = 16;
    for (int j = 0; j < 5; j++) begin
      for (int off = 0; off < 4; off += lsize[j]) begin
        addr = idx * 4 + off;
        w    = mem_init[idx];
        case (lf[j])
          3'b000:  e = {{24{w[8*off+7]}}, w[8*off +: 8]};
          3'b001:  e = {{16{w[8*off+15]}}, w[8*off +: 16]};
          3'b100:  e = {24'h0, w[8*off +: 8]};
          3'b101:  e = {16'h0, w[8*off +: 16]};
          default: e = w;
        endcase
        emit(i_type(addr[11:0], 5'd0, lf[j], 5'd3, op_load));
        emit(s_type(12'h200, 5'd3, 5'd0, 3'b010));
        emit(ebreak_word);
        add_row($sformatf("load f3=%0d off=%0d", lf[j], off), 32'h200, e);
        idx++;
      end
    end
    v   = 32'hc3b2_a190;
    idx = 160;
    for (int j = 0; j < 2; j++) begin
      for (int off = 0; off < 4; off += j + 1) begin
        addr = idx * 4 + off;
        mask = ((j == 0) ? 4'b0001 : 4'b0011) << off;
        e    = mem_init[idx];
        for (int k = 0; k < 4; k++) begin
          if (mask[k]) begin
            e[8*k +: 8] = v[8*k +: 8]; // data is not shifted into the lane
          end
        end
        load_const(5'd4, v);
        emit(s_type(addr[11:0], 5'd4, 5'd0, j[2:0]));
        emit(ebreak_word);
        add_row($sformatf("store f3=%0d off=%0d", j, off), {addr[31:2], 2'b00}, e);
        idx++;
      end
    end
  endtask

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic run_row(input int r);
    row_t        row;
    logic [31:0] pc_held;
    logic [31:0] got;
    int          n;
    bit          ok;
    row      = tbl[r];
    ok       = 1'b1;
    restart  = 1'b1;
    fill_mem = 1'b1;
    for (int i = 0; i < 8; i++) begin
      imem[i] = row.prog[i];
    end
    step();
    restart  = 1'b0;
    fill_mem = 1'b0;
    do @(posedge clk); while (!rst_n);
    #2;
    n = 0;
    while (!halt && n < cycle_limit) begin
      step();
      n++;
    end
    if (!halt) begin
      $display("test %0d %s: no halt within %0d cycles", r, names[r], cycle_limit);
      errors++;
      ok = 1'b0;
    end else begin
      pc_held = pc;
      if (imem_off < 32'd32) begin
        imem[imem_off[4:2]] = s_type(12'h1fc, 5'd0, 5'd0, 3'b010); // store halt must block
      end
      repeat (hold_cycles) begin
        step();
        if (halt !== 1'b1) begin
          $display("ERROR halt: got %h expected %h", halt, 1'b1);
          errors++;
          ok = 1'b0;
        end
        if (pc !== pc_held) begin
          $display("ERROR pc: got %h expected %h", pc, pc_held);
          errors++;
          ok = 1'b0;
        end
        if (dmem_req.wen !== 1'b0) begin
          $display("ERROR dmem_req.wen: got %h expected %h", dmem_req.wen, 1'b0);
          errors++;
          ok = 1'b0;
        end
      end
    end
    got = dmem[row.chk_addr[9:2]];
    if (got !== row.want) begin
      $display("ERROR dmem[%h]: got %h expected %h", row.chk_addr, got, row.want);
      errors++;
      ok = 1'b0;
    end
    if (ok) begin
      passed++;
    end else begin
      failed++;
    end
    $display("test %0d %s: %s", r, names[r], ok ? "ok" : "failed");
  endtask

  initial begin
    logic [31:0] x;
    restart   = 1'b0;
    fill_mem  = 1'b0;
    errors    = 0;
    passed    = 0;
    failed    = 0;
    pn        = 0;
    tbl_ready = 1'b0;
    for (int i = 0; i < 8; i++) begin
      imem[i] = ebreak_word;
    end
    x = 32'h11c;
    for (int i = 0; i < 256; i++) begin
      x           = xorshift(x);
      mem_init[i] = x;
    end
    build_alu_rows();
    build_flow_rows();
    build_mem_rows();
    tbl_ready = 1'b1;
    wait (rst_n);
    step();
    for (int r = 0; r < tbl.size(); r++) begin
      run_row(r);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tbl.size(), passed, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // limit grows with the number of programs
  initial begin
    wait (tbl_ready);
    #(tbl.size() * row_cycles * period + reset_cycles * period);
    $display("watchdog expired before all tests finished");
    $display("** FAIL **");
    $finish;
  end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int half_period  = 10,
  parameter int reset_cycles = 8
) (
  input  logic restart,  // sampled at the rising edge
  output logic clk,
  output logic rst_n
);

  int low_left;

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    low_left = reset_cycles;
    forever #half_period clk = ~clk;
  end

  // rst_n low for reset_cycles edges after start or after a restart pulse
  always @(posedge clk) begin
    if (restart) begin
      low_left = reset_cycles;
    end else if (low_left > 0) begin
      low_left = low_left - 1;
    end
    #2 rst_n = (low_left == 0); // moves with the other tb inputs
  end

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  output logic [xlen-1:0] pc,
  input  logic [xlen-1:0] imem_rdata,
  output dmem_req_t       dmem_req,
  input  logic [xlen-1:0] dmem_rdata,
  output logic            halt
);

  decoded_t        dec;
  dmem_req_t       lsu_req;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] wb_data;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_target;
  logic [xlen-1:0] pc_next;
  logic            take_branch;
  logic            run;

  assign run = rst_n && !halt; // architectural side effects allowed

  rv_decoder i_rv_decoder (
    .instr (imem_rdata),
    .dec   (dec)
  );

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rd       (dec.rd),
    .wen      (dec.reg_wen & run),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu i_rv_alu (
    .dec         (dec),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .result      (alu_result),
    .take_branch (take_branch)
  );

  rv_lsu i_rv_lsu (
    .dec        (dec),
    .addr       (alu_result),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (lsu_req),
    .load_data  (load_data)
  );

  always_comb begin
    dmem_req     = lsu_req;
    dmem_req.ren = lsu_req.ren & rst_n;
    dmem_req.wen = lsu_req.wen & run;
  end

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + dec.imm; // branch and jal

  always_comb begin
    if (dec.is_jalr) begin
      pc_next = {alu_result[xlen-1:1], 1'b0};
    end else if (take_branch || dec.is_jump) begin
      pc_next = pc_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_comb begin
    case (dec.wb_sel)
      wb_load:  wb_data = load_data;
      wb_link:  wb_data = pc_plus4;
      wb_upper: wb_data = dec.imm;  // lui
      default:  wb_data = alu_result;
    endcase
  end

  // ebreak parks the pc on itself and raises halt
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (!halt) begin
      if (dec.halt) begin
        halt <= 1'b1;
      end else begin
        pc <= pc_next;
      end
    end
  end

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
  ) else $error("pc misaligned %h", pc);

endmodule

/* hdl/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu import rv_pkg::*; (
  input  decoded_t        dec,
  input  logic [xlen-1:0] addr,
  input  logic [xlen-1:0] rs2_data,
  input  logic [xlen-1:0] dmem_rdata,
  output dmem_req_t       dmem_req,
  output logic [xlen-1:0] load_data
);

  logic [3:0]  wmask;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // store lanes from width and low address bits
  always_comb begin
    wmask = 4'b0000;
    if (dec.mem_write) begin
      case (dec.funct3)
        f3_byte: wmask = 4'b0001 << addr[1:0];
        f3_half: wmask = addr[1] ? 4'b1100 : 4'b0011;
        f3_word: wmask = 4'b1111;
        default: wmask = 4'b0000; // not a store width
      endcase
    end
  end

  always_comb begin
    dmem_req.addr  = addr;
    dmem_req.wdata = rs2_data; // unshifted, lane k takes byte k
    dmem_req.wmask = wmask;
    dmem_req.ren   = dec.mem_read;
    dmem_req.wen   = dec.mem_write;
  end

  assign byte_sel = dmem_rdata[{addr[1:0], 3'b000} +: 8];
  assign half_sel = dmem_rdata[{addr[1], 4'b0000} +: 16];

  always_comb begin
    case (dec.funct3)
      f3_byte:   load_data = {{24{byte_sel[7]}}, byte_sel};
      f3_half:   load_data = {{16{half_sel[15]}}, half_sel};
      f3_byte_u: load_data = {24'h00_0000, byte_sel};
      f3_half_u: load_data = {16'h0000, half_sel};
      default:   load_data = dmem_rdata; // lw
    endcase
  end

  // decoder must only flag stores with a legal width
  always_comb begin
    if (dmem_req.wen) begin
      a_wen_mask: assert (dmem_req.wmask != 4'b0000)
        else $error("store with empty byte mask, funct3 %0h", dec.funct3);
    end
  end

endmodule

/* hdl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
  input  decoded_t        dec,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output logic [xlen-1:0] result,
  output logic            take_branch
);

  logic [xlen-1:0]       op_a;
  logic [xlen-1:0]       op_b;
  logic [xlen:0]         diff;     // top bit is carry out
  logic                  overflow;
  logic                  lt_s;
  logic                  lt_u;
  logic                  eq;
  logic [reg_addr_w-1:0] shamt;
  logic                  cond;

  assign op_a  = dec.use_pc ? pc : rs1_data;
  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[reg_addr_w-1:0];

  // a - b as a + ~b + 1, carry kept for unsigned compare
  assign diff = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1;

  assign overflow = (op_a[xlen-1] != op_b[xlen-1]) && (diff[xlen-1] != op_a[xlen-1]);
  assign lt_s     = diff[xlen-1] ^ overflow;
  assign lt_u     = ~diff[xlen]; // no carry means borrow
  assign eq       = (diff[xlen-1:0] == '0);

  always_comb begin
    case (dec.alu_op)
      alu_add:  result = op_a + op_b;
      alu_sub:  result = diff[xlen-1:0];
      alu_sll:  result = op_a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: result = {{(xlen-1){1'b0}}, lt_u};
      alu_xor:  result = op_a ^ op_b;
      alu_srl:  result = op_a >> shamt;
      alu_sra:  result = $signed(op_a) >>> shamt; // sign fill
      alu_or:   result = op_a | op_b;
      alu_and:  result = op_a & op_b;
      default:  result = op_a + op_b;
    endcase
  end

  // branches never select pc or imm, so the flags above compare rs1 with rs2
  always_comb begin
    case (dec.funct3)
      f3_beq:  cond = eq;
      f3_bne:  cond = ~eq;
      f3_blt:  cond = lt_s;
      f3_bge:  cond = ~lt_s;
      f3_bltu: cond = lt_u;
      f3_bgeu: cond = ~lt_u;
      default: cond = 1'b0;
    endcase
  end

  assign take_branch = dec.is_branch & cond;

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  input  logic [reg_addr_w-1:0] rd,
  input  logic                  wen,
  input  logic [xlen-1:0]       wdata,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data
);

  // x0 is an entry that only reset writes
  logic [xlen-1:0] regs [0:31];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regs[0] <= '0;
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // combinational reads
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // the write port never reaches x0
  a_x0_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((rs1 != '0) || (rs1_data == '0)) && ((rs2 != '0) || (rs2_data == '0))
  ) else $error("x0 read back nonzero");

endmodule

/* hdl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
  input  logic [xlen-1:0] instr,
  output decoded_t        dec
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            funct7_b5;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_shamt;
  alu_op_e         arith_op;

  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30]; // sub / sra select

  // immediate forms, all sign extended from instr[31]
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign imm_shamt = {{(xlen-reg_addr_w){1'b0}}, instr[24:20]};

  // arithmetic function shared by op_reg and op_imm
  always_comb begin
    case (funct3)
      f3_add_sub: arith_op = (opcode == op_reg && funct7_b5) ? alu_sub : alu_add;
      f3_sll:     arith_op = alu_sll;
      f3_slt:     arith_op = alu_slt;
      f3_sltu:    arith_op = alu_sltu;
      f3_xor:     arith_op = alu_xor;
      f3_srl_sra: arith_op = funct7_b5 ? alu_sra : alu_srl; // srai too
      f3_or:      arith_op = alu_or;
      f3_and:     arith_op = alu_and;
      default:    arith_op = alu_add;
    endcase
  end

  always_comb begin
    dec        = '0;
    dec.rs1    = instr[19:15];
    dec.rs2    = instr[24:20];
    dec.rd     = instr[11:7];
    dec.funct3 = funct3;
    dec.imm    = imm_i;
    dec.alu_op = alu_add; // address and link arithmetic
    dec.wb_sel = wb_alu;
    case (opcode)
      op_reg: begin
        dec.alu_op  = arith_op;
        dec.reg_wen = 1'b1;
      end
      op_imm: begin
        dec.alu_op  = arith_op;
        dec.use_imm = 1'b1;
        dec.reg_wen = 1'b1;
        if (funct3 == f3_sll || funct3 == f3_srl_sra) begin
          dec.imm = imm_shamt; // drop funct7 bits from shift imm
        end
      end
      op_load: begin
        dec.use_imm  = 1'b1;
        dec.reg_wen  = 1'b1;
        dec.mem_read = 1'b1;
        dec.wb_sel   = wb_load;
      end
      op_store: begin
        dec.imm       = imm_s;
        dec.use_imm   = 1'b1;
        dec.mem_write = 1'b1;
      end
      op_branch: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1; // alu compares rs1 against rs2
      end
      op_jal: begin
        dec.imm     = imm_j;
        dec.is_jump = 1'b1;
        dec.reg_wen = 1'b1;
        dec.wb_sel  = wb_link;
      end
      op_jalr: begin
        dec.use_imm = 1'b1;
        dec.is_jump = 1'b1;
        dec.is_jalr = 1'b1;
        dec.reg_wen = 1'b1;
        dec.wb_sel  = wb_link;
      end
      op_lui: begin
        dec.imm     = imm_u;
        dec.reg_wen = 1'b1;
        dec.wb_sel  = wb_upper;
      end
      op_auipc: begin
        dec.imm     = imm_u;
        dec.use_pc  = 1'b1;
        dec.use_imm = 1'b1;
        dec.reg_wen = 1'b1;
      end
      op_system: dec.halt = (instr[31:20] == 12'h001); // ebreak only
      default: ;
    endcase
  end

endmodule

/* hdl/rv_pkg.sv */
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // major opcodes, instr[6:0]
  localparam logic [6:0] op_reg    = 7'b011_0011;
  localparam logic [6:0] op_imm    = 7'b001_0011;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_branch = 7'b110_0011;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;
  localparam logic [6:0] op_system = 7'b111_0011;

  // funct3 for register and immediate arithmetic
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // funct3 for loads and stores, access width
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu, wb_load, wb_link, wb_upper
  } wb_sel_e;

  typedef struct packed {
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [2:0]            funct3;
    logic [xlen-1:0]       imm;
    alu_op_e               alu_op;
    logic                  use_imm;   // operand b is imm
    logic                  use_pc;    // operand a is pc
    logic                  reg_wen;
    logic                  mem_read;
    logic                  mem_write;
    logic                  is_branch;
    logic                  is_jump;   // jal and jalr
    logic                  is_jalr;
    wb_sel_e               wb_sel;
    logic                  halt;
  } decoded_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      wmask;   // one bit per byte lane
    logic            ren;
    logic            wen;
  } dmem_req_t;

endpackage
